/* engine_cfg.svh */
// --------------------------------------------------
// Build sizes. FIFO depth must be a power of two, and
// the threshold must leave room for packets in flight
// --------------------------------------------------
`ifndef ENGINE_CFG_SVH
`define ENGINE_CFG_SVH

`define ENGINE_FIFO_DEPTH  16
`define ENGINE_PROG_THRESH 12

`define ENGINE_ADDR_W      32
`define ENGINE_DATA_W      32
`define ENGINE_WORD_BYTES  4

`endif

/* engine_pkg.sv */
// --------------------------------------------------
// Shared types. addr_t carries both byte addresses
// and vertex indices
// --------------------------------------------------
`include "engine_cfg.svh"

package engine_pkg;

    typedef logic [`ENGINE_ADDR_W-1:0] addr_t;
    typedef logic [`ENGINE_DATA_W-1:0] data_t;
    typedef logic [15:0]               count_t;

    // Destination of a memory response
    typedef logic [0:0] module_id_t;
    localparam module_id_t MODULE_CONFIG    = 1'b0;
    localparam module_id_t MODULE_GENERATOR = 1'b1;

    typedef logic [0:0] cmd_t;
    localparam cmd_t CMD_READ  = 1'b0;
    localparam cmd_t CMD_WRITE = 1'b1;

    // Selected by the low address bits of a config packet
    typedef logic [1:0] cfg_reg_t;
    localparam cfg_reg_t CFG_BASE  = 2'd0;
    localparam cfg_reg_t CFG_COUNT = 2'd1;
    localparam cfg_reg_t CFG_MODE  = 2'd2;

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_RUN,
        GEN_DRAIN
    } gen_state_t;

endpackage : engine_pkg

/* pkt_stream_if.sv */
// --------------------------------------------------
// One packet stream. Source pushes only while
// prog_full is low
// --------------------------------------------------
`timescale 1ns/10ps

interface pkt_stream_if;

    logic                   valid;
    engine_pkg::module_id_t id;
    engine_pkg::cmd_t       cmd;
    engine_pkg::addr_t      addr;
    engine_pkg::data_t      data;
    logic                   prog_full;

    modport src (
        output valid, id, cmd, addr, data,
        input  prog_full
    );

    modport sink (
        input  valid, id, cmd, addr, data,
        output prog_full
    );

endinterface : pkt_stream_if

/* packet_fifo.sv */
// --------------------------------------------------
// Synchronous packet FIFO, DEPTH a power of two.
// Data is valid one cycle after pop. Never pop empty
// --------------------------------------------------
`timescale 1ns/10ps

module packet_fifo #(
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 12
) (
    input  logic                   ap_clk,
    input  logic                   areset_csr_engine,
    input  logic                   push,
    input  engine_pkg::module_id_t id,
    input  engine_pkg::cmd_t       cmd,
    input  engine_pkg::addr_t      addr,
    input  engine_pkg::data_t      data,
    input  logic                   pop,
    output logic                   valid,
    output engine_pkg::module_id_t out_id,
    output engine_pkg::cmd_t       out_cmd,
    output engine_pkg::addr_t      out_addr,
    output engine_pkg::data_t      out_data,
    output logic                   empty,
    output logic                   prog_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    engine_pkg::module_id_t mem_id   [DEPTH];
    engine_pkg::cmd_t       mem_cmd  [DEPTH];
    engine_pkg::addr_t      mem_addr [DEPTH];
    engine_pkg::data_t      mem_data [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;

    assign empty      = (count == '0);
    assign count_next = count + CNT_W'(push) - CNT_W'(pop);

    // --------------------------------------------------
    // Pointers, occupancy and flags
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            valid     <= 1'b0;
            prog_full <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count     <= count_next;
            valid     <= pop;
            // Flag reflects the fill level after this edge
            prog_full <= (count_next >= CNT_W'(PROG_THRESH));
        end
    end

    // Storage and output register
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem_id[wr_ptr]   <= id;
            mem_cmd[wr_ptr]  <= cmd;
            mem_addr[wr_ptr] <= addr;
            mem_data[wr_ptr] <= data;
        end
        if (pop) begin
            out_id   <= mem_id[rd_ptr];
            out_cmd  <= mem_cmd[rd_ptr];
            out_addr <= mem_addr[rd_ptr];
            out_data <= mem_data[rd_ptr];
        end
    end

    // Writer honours prog_full, reader checks empty
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        push |-> (count != CNT_W'(DEPTH)));
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        pop |-> !empty);

endmodule : packet_fifo

/* response_router.sv */
// --------------------------------------------------
// 1-to-2 memory response router. Pops only when no
// destination is holding off
// --------------------------------------------------
`timescale 1ns/10ps

module response_router (
    input  logic       ap_clk,
    input  logic       areset_csr_engine,
    pkt_stream_if.sink in,
    output logic       fifo_pop,
    input  logic       fifo_empty,
    pkt_stream_if.src  to_config,
    pkt_stream_if.src  to_generator
);

    logic hold;

    // Config side never fills, so in practice this is the generator
    assign hold         = to_config.prog_full || to_generator.prog_full;
    assign fifo_pop     = !fifo_empty && !hold;
    assign in.prog_full = hold;

    // --------------------------------------------------
    // Steer the popped packet by its module id
    // --------------------------------------------------
    assign to_config.valid = in.valid && (in.id == engine_pkg::MODULE_CONFIG);
    assign to_config.id    = in.id;
    assign to_config.cmd   = in.cmd;
    assign to_config.addr  = in.addr;
    assign to_config.data  = in.data;

    assign to_generator.valid = in.valid && (in.id == engine_pkg::MODULE_GENERATOR);
    assign to_generator.id    = in.id;
    assign to_generator.cmd   = in.cmd;
    assign to_generator.addr  = in.addr;
    assign to_generator.data  = in.data;

    // Input data only ever follows our own pop
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        in.valid |-> $past(fifo_pop));
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        $onehot0({to_config.valid, to_generator.valid}));

endmodule : response_router

/* rw_config_regs.sv */
// --------------------------------------------------
// Job registers. Writing COUNT arms a job, so it is
// written after BASE and MODE
// --------------------------------------------------
`timescale 1ns/10ps

module rw_config_regs (
    input  logic               ap_clk,
    input  logic               areset_csr_engine,
    pkt_stream_if.sink         cfg_in,
    output engine_pkg::addr_t  cfg_base,
    output engine_pkg::count_t cfg_count,
    output engine_pkg::cmd_t   cfg_mode,
    output logic               cfg_armed,
    input  logic               job_done
);

    engine_pkg::cfg_reg_t sel;

    assign sel              = engine_pkg::cfg_reg_t'(cfg_in.addr[1:0]);
    assign cfg_in.prog_full = 1'b0;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            cfg_armed <= 1'b0;
        end else if (cfg_in.valid && (sel == engine_pkg::CFG_COUNT)) begin
            cfg_armed <= 1'b1;
        end else if (job_done) begin
            cfg_armed <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Register file
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (cfg_in.valid) begin
            case (sel)
                engine_pkg::CFG_BASE: begin
                    cfg_base <= engine_pkg::addr_t'(cfg_in.data);
                end
                engine_pkg::CFG_COUNT: begin
                    cfg_count <= engine_pkg::count_t'(cfg_in.data);
                end
                engine_pkg::CFG_MODE: begin
                    cfg_mode <= engine_pkg::cmd_t'(cfg_in.data[0]);
                end
                default: begin
                end
            endcase
        end
    end

    // Generator finishes only jobs that were armed here
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        job_done |-> cfg_armed);

endmodule : rw_config_regs

/* rw_generator.sv */
// --------------------------------------------------
// Turns engine packets into memory requests and hands
// read data back. A job of count 0 finishes at once
// --------------------------------------------------
`timescale 1ns/10ps
`include "engine_cfg.svh"

module rw_generator (
    input  logic               ap_clk,
    input  logic               areset_csr_engine,
    input  engine_pkg::addr_t  cfg_base,
    input  engine_pkg::count_t cfg_count,
    input  engine_pkg::cmd_t   cfg_mode,
    input  logic               cfg_armed,
    output logic               job_done,
    pkt_stream_if.sink         engine_in,
    output logic               engine_pop,
    input  logic               engine_empty,
    pkt_stream_if.sink         mem_rsp_in,
    pkt_stream_if.src          mem_req_out,
    pkt_stream_if.src          engine_req_out,
    output logic               done_out
);

    localparam engine_pkg::addr_t WORD_BYTES = `ENGINE_WORD_BYTES;

    engine_pkg::gen_state_t state;
    engine_pkg::gen_state_t state_next;
    engine_pkg::count_t     pop_cnt;
    engine_pkg::count_t     req_cnt;
    engine_pkg::count_t     rsp_cnt;
    logic                   out_full;
    logic                   finish;

    assign out_full   = mem_req_out.prog_full || engine_req_out.prog_full;
    assign engine_pop = (state == engine_pkg::GEN_RUN) && !engine_empty && !out_full &&
                        (pop_cnt != cfg_count);

    // Back-pressure seen by the feeding FIFOs
    assign engine_in.prog_full  = out_full;
    assign mem_rsp_in.prog_full = engine_req_out.prog_full;

    // --------------------------------------------------
    // Job FSM
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        finish     = 1'b0;
        case (state)
            engine_pkg::GEN_IDLE: begin
                // Armed stays high for one cycle after job_done
                if (cfg_armed && !job_done) begin
                    state_next = engine_pkg::GEN_RUN;
                end
            end
            engine_pkg::GEN_RUN: begin
                if (req_cnt == cfg_count) begin
                    if (cfg_mode == engine_pkg::CMD_WRITE) begin
                        finish     = 1'b1;
                        state_next = engine_pkg::GEN_IDLE;
                    end else begin
                        state_next = engine_pkg::GEN_DRAIN;
                    end
                end
            end
            engine_pkg::GEN_DRAIN: begin
                if (rsp_cnt == cfg_count) begin
                    finish     = 1'b1;
                    state_next = engine_pkg::GEN_IDLE;
                end
            end
            default: begin
                state_next = engine_pkg::GEN_IDLE;
            end
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state                <= engine_pkg::GEN_IDLE;
            pop_cnt              <= '0;
            req_cnt              <= '0;
            rsp_cnt              <= '0;
            job_done             <= 1'b0;
            done_out             <= 1'b1;
            mem_req_out.valid    <= 1'b0;
            engine_req_out.valid <= 1'b0;
        end else begin
            state                <= state_next;
            job_done             <= finish;
            done_out             <= (state_next == engine_pkg::GEN_IDLE);
            mem_req_out.valid    <= engine_in.valid;
            engine_req_out.valid <= mem_rsp_in.valid;
            if (state == engine_pkg::GEN_IDLE) begin
                pop_cnt <= '0;
                req_cnt <= '0;
                rsp_cnt <= '0;
            end else begin
                pop_cnt <= pop_cnt + engine_pkg::count_t'(engine_pop);
                req_cnt <= req_cnt + engine_pkg::count_t'(engine_in.valid);
                rsp_cnt <= rsp_cnt + engine_pkg::count_t'(mem_rsp_in.valid);
            end
        end
    end

    // --------------------------------------------------
    // Request and response payloads
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (engine_in.valid) begin
            mem_req_out.id   <= engine_pkg::MODULE_GENERATOR;
            mem_req_out.cmd  <= cfg_mode;
            mem_req_out.addr <= cfg_base + engine_in.addr * WORD_BYTES;
            mem_req_out.data <= (cfg_mode == engine_pkg::CMD_WRITE) ? engine_in.data : '0;
        end
        if (mem_rsp_in.valid) begin
            engine_req_out.id   <= mem_rsp_in.id;
            engine_req_out.cmd  <= mem_rsp_in.cmd;
            engine_req_out.addr <= mem_rsp_in.addr;
            engine_req_out.data <= mem_rsp_in.data;
        end
    end

    // Read data comes back only while a job is open
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        mem_rsp_in.valid |-> (state != engine_pkg::GEN_IDLE));

endmodule : rw_generator

/* engine_read_write.sv */
// --------------------------------------------------
// Read/write engine top. Push only while prog_full is
// low; output valid follows rd_en by one cycle
// --------------------------------------------------
`timescale 1ns/10ps
`include "engine_cfg.svh"

module engine_read_write (
    input  logic                   ap_clk,
    input  logic                   areset_csr_engine,
    // Engine responses
    input  logic                   engine_rsp_valid,
    input  engine_pkg::addr_t      engine_rsp_addr,
    input  engine_pkg::data_t      engine_rsp_data,
    output logic                   engine_rsp_prog_full,
    // Memory responses
    input  logic                   mem_rsp_valid,
    input  engine_pkg::module_id_t mem_rsp_id,
    input  engine_pkg::addr_t      mem_rsp_addr,
    input  engine_pkg::data_t      mem_rsp_data,
    output logic                   mem_rsp_prog_full,
    // Memory requests
    input  logic                   mem_req_rd_en,
    output logic                   mem_req_valid,
    output engine_pkg::cmd_t       mem_req_cmd,
    output engine_pkg::addr_t      mem_req_addr,
    output engine_pkg::data_t      mem_req_data,
    // Engine requests
    input  logic                   engine_req_rd_en,
    output logic                   engine_req_valid,
    output engine_pkg::addr_t      engine_req_addr,
    output engine_pkg::data_t      engine_req_data,
    output logic                   done_out
);

    pkt_stream_if mem_rsp_if ();
    pkt_stream_if cfg_if ();
    pkt_stream_if gen_rsp_if ();
    pkt_stream_if eng_rsp_if ();
    pkt_stream_if mem_req_if ();
    pkt_stream_if eng_req_if ();

    logic               mem_rsp_pop;
    logic               mem_rsp_empty;
    logic               eng_rsp_pop;
    logic               eng_rsp_empty;
    logic               mem_req_empty;
    logic               eng_req_empty;
    engine_pkg::addr_t  cfg_base;
    engine_pkg::count_t cfg_count;
    engine_pkg::cmd_t   cfg_mode;
    logic               cfg_armed;
    logic               job_done;

    // --------------------------------------------------
    // Input FIFOs
    // --------------------------------------------------
    packet_fifo #(
        .DEPTH      (`ENGINE_FIFO_DEPTH),
        .PROG_THRESH(`ENGINE_PROG_THRESH)
    ) eng_rsp_fifo_inst (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push             (engine_rsp_valid),
        .id               (engine_pkg::MODULE_GENERATOR),
        .cmd              (engine_pkg::CMD_WRITE),
        .addr             (engine_rsp_addr),
        .data             (engine_rsp_data),
        .pop              (eng_rsp_pop),
        .valid            (eng_rsp_if.valid),
        .out_id           (eng_rsp_if.id),
        .out_cmd          (eng_rsp_if.cmd),
        .out_addr         (eng_rsp_if.addr),
        .out_data         (eng_rsp_if.data),
        .empty            (eng_rsp_empty),
        .prog_full        (engine_rsp_prog_full)
    );

    packet_fifo #(
        .DEPTH      (`ENGINE_FIFO_DEPTH),
        .PROG_THRESH(`ENGINE_PROG_THRESH)
    ) mem_rsp_fifo_inst (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push             (mem_rsp_valid),
        .id               (mem_rsp_id),
        .cmd              (engine_pkg::CMD_READ),
        .addr             (mem_rsp_addr),
        .data             (mem_rsp_data),
        .pop              (mem_rsp_pop),
        .valid            (mem_rsp_if.valid),
        .out_id           (mem_rsp_if.id),
        .out_cmd          (mem_rsp_if.cmd),
        .out_addr         (mem_rsp_if.addr),
        .out_data         (mem_rsp_if.data),
        .empty            (mem_rsp_empty),
        .prog_full        (mem_rsp_prog_full)
    );

    // --------------------------------------------------
    // Routing, configuration and generation
    // --------------------------------------------------
    response_router response_router_inst (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .in               (mem_rsp_if.sink),
        .fifo_pop         (mem_rsp_pop),
        .fifo_empty       (mem_rsp_empty),
        .to_config        (cfg_if.src),
        .to_generator     (gen_rsp_if.src)
    );

    rw_config_regs rw_config_regs_inst (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .cfg_in           (cfg_if.sink),
        .cfg_base         (cfg_base),
        .cfg_count        (cfg_count),
        .cfg_mode         (cfg_mode),
        .cfg_armed        (cfg_armed),
        .job_done         (job_done)
    );

    rw_generator rw_generator_inst (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .cfg_base         (cfg_base),
        .cfg_count        (cfg_count),
        .cfg_mode         (cfg_mode),
        .cfg_armed        (cfg_armed),
        .job_done         (job_done),
        .engine_in        (eng_rsp_if.sink),
        .engine_pop       (eng_rsp_pop),
        .engine_empty     (eng_rsp_empty),
        .mem_rsp_in       (gen_rsp_if.sink),
        .mem_req_out      (mem_req_if.src),
        .engine_req_out   (eng_req_if.src),
        .done_out         (done_out)
    );

    // --------------------------------------------------
    // Output FIFOs
    // --------------------------------------------------
    packet_fifo #(
        .DEPTH      (`ENGINE_FIFO_DEPTH),
        .PROG_THRESH(`ENGINE_PROG_THRESH)
    ) mem_req_fifo_inst (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push             (mem_req_if.valid),
        .id               (mem_req_if.id),
        .cmd              (mem_req_if.cmd),
        .addr             (mem_req_if.addr),
        .data             (mem_req_if.data),
        .pop              (mem_req_rd_en && !mem_req_empty),
        .valid            (mem_req_valid),
        .out_id           (),
        .out_cmd          (mem_req_cmd),
        .out_addr         (mem_req_addr),
        .out_data         (mem_req_data),
        .empty            (mem_req_empty),
        .prog_full        (mem_req_if.prog_full)
    );

    packet_fifo #(
        .DEPTH      (`ENGINE_FIFO_DEPTH),
        .PROG_THRESH(`ENGINE_PROG_THRESH)
    ) eng_req_fifo_inst (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push             (eng_req_if.valid),
        .id               (eng_req_if.id),
        .cmd              (eng_req_if.cmd),
        .addr             (eng_req_if.addr),
        .data             (eng_req_if.data),
        .pop              (engine_req_rd_en && !eng_req_empty),
        .valid            (engine_req_valid),
        .out_id           (),
        .out_cmd          (),
        .out_addr         (engine_req_addr),
        .out_data         (engine_req_data),
        .empty            (eng_req_empty),
        .prog_full        (eng_req_if.prog_full)
    );

endmodule : engine_read_write

/* tb_engine_read_write.sv */
// --------------------------------------------------
// Testbench for the read/write engine. Config goes in
// as memory responses, and jobs never overlap
// --------------------------------------------------
`timescale 1ns/10ps
`include "engine_cfg.svh"

module tb_engine_read_write;

    localparam int TIMEOUT = 2000;

    logic                   ap_clk = 1'b0;
    logic                   areset_csr_engine;
    logic                   engine_rsp_valid;
    engine_pkg::addr_t      engine_rsp_addr;
    engine_pkg::data_t      engine_rsp_data;
    logic                   engine_rsp_prog_full;
    logic                   mem_rsp_valid = 1'b0;
    engine_pkg::module_id_t mem_rsp_id = '0;
    engine_pkg::addr_t      mem_rsp_addr = '0;
    engine_pkg::data_t      mem_rsp_data = '0;
    logic                   mem_rsp_prog_full;
    logic                   mem_req_rd_en = 1'b0;
    logic                   mem_req_valid;
    engine_pkg::cmd_t       mem_req_cmd;
    engine_pkg::addr_t      mem_req_addr;
    engine_pkg::data_t      mem_req_data;
    logic                   engine_req_rd_en = 1'b0;
    logic                   engine_req_valid;
    engine_pkg::addr_t      engine_req_addr;
    engine_pkg::data_t      engine_req_data;
    logic                   done_out;

    // Expected outputs as {cmd, addr, data} and {addr, data}
    logic [64:0] exp_mem_q[$];
    logic [63:0] exp_eng_q[$];
    // Pending memory responses as {id, addr, data}
    logic [64:0] cfg_q[$];
    logic [64:0] rd_q[$];

    logic [31:0] stim_rng = 32'hb1c2;
    logic [31:0] rd_rng = 32'hb1c2;
    int          mon_errors = 0;
    int          seq_errors = 0;
    int          mem_seen = 0;
    int          eng_seen = 0;
    int          answered_cnt = 0;

    engine_read_write engine_read_write_inst (.*);

    initial begin
        forever #4 ap_clk = ~ap_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Memory contents, a mix of every address bit
    function automatic engine_pkg::data_t memory_word(input engine_pkg::addr_t addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
    endfunction

    // Request for vertex index under base and mode
    function automatic logic [64:0] expected_request(input engine_pkg::addr_t base,
            input int index, input engine_pkg::cmd_t mode, input engine_pkg::data_t value);
        engine_pkg::addr_t addr;
        engine_pkg::data_t data;
        addr = base + engine_pkg::addr_t'(index) * engine_pkg::addr_t'(`ENGINE_WORD_BYTES);
        data = (mode == engine_pkg::CMD_WRITE) ? value : '0;
        return {mode, addr, data};
    endfunction

    function automatic int count_mismatch(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        int bad;
        bad = 0;
        assert (got === exp) else begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            bad = 1;
        end
        return bad;
    endfunction

    task automatic finish_run();
        $display("errors: %0d in output checks, %0d in sequence checks", mon_errors, seq_errors);
        if (mon_errors == 0 && seq_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic wait_done(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (done_out !== level) begin
            @(posedge ap_clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                seq_errors++;
                $display("timeout: done_out never reached %0d while %s", level, what);
                finish_run();
            end
        end
    endtask

    task automatic wait_room();
        int cycles;
        cycles = 0;
        while (engine_rsp_prog_full !== 1'b0) begin
            @(posedge ap_clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                seq_errors++;
                $display("timeout: engine response input stayed held off");
                finish_run();
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_mem_q.size() != 0 || exp_eng_q.size() != 0) begin
            @(posedge ap_clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                seq_errors++;
                $display("timeout: %0d memory and %0d engine packets never arrived",
                         exp_mem_q.size(), exp_eng_q.size());
                finish_run();
            end
        end
    endtask

    task automatic send_config(input engine_pkg::cfg_reg_t sel, input engine_pkg::data_t value);
        cfg_q.push_back({engine_pkg::MODULE_CONFIG, engine_pkg::addr_t'(sel), value});
    endtask

    // --------------------------------------------------
    // One job: configure, push packets, wait, account
    // --------------------------------------------------
    task automatic run_job(input engine_pkg::cmd_t mode, input engine_pkg::addr_t base,
            input int count);
        logic [64:0]       req;
        engine_pkg::data_t value;
        int                mem_start;
        int                eng_start;
        int                ans_start;
        mem_start = mem_seen;
        eng_start = eng_seen;
        ans_start = answered_cnt;
        send_config(engine_pkg::CFG_BASE, base);
        send_config(engine_pkg::CFG_MODE, engine_pkg::data_t'(mode));
        send_config(engine_pkg::CFG_COUNT, engine_pkg::data_t'(count));
        wait_done(1'b0, "arming the job");
        for (int i = 0; i < count; i++) begin
            stim_rng = xorshift32(stim_rng);
            value = stim_rng;
            repeat (int'(stim_rng[9:8])) @(posedge ap_clk);
            wait_room();
            seq_errors += count_mismatch("done_out", 32'(done_out), 32'd0);
            req = expected_request(base, i, mode, value);
            exp_mem_q.push_back(req);
            if (mode == engine_pkg::CMD_READ) begin
                exp_eng_q.push_back({req[63:32], memory_word(req[63:32])});
            end
            @(posedge ap_clk);
            engine_rsp_valid <= 1'b1;
            engine_rsp_addr  <= engine_pkg::addr_t'(i);
            engine_rsp_data  <= value;
            @(posedge ap_clk);
            engine_rsp_valid <= 1'b0;
        end
        wait_done(1'b1, "finishing the job");
        if (mode == engine_pkg::CMD_READ) begin
            assert (answered_cnt - ans_start == count) else begin
                $display("done_out rose after %0d of %0d read answers",
                         answered_cnt - ans_start, count);
                seq_errors++;
            end
        end
        wait_drain();
        assert (mem_seen - mem_start == count) else begin
            $display("job saw %0d memory requests instead of %0d", mem_seen - mem_start, count);
            seq_errors++;
        end
        assert (eng_seen - eng_start == ((mode == engine_pkg::CMD_READ) ? count : 0)) else begin
            $display("job saw %0d engine requests for count %0d", eng_seen - eng_start, count);
            seq_errors++;
        end
    endtask

    initial begin
        areset_csr_engine = 1'b1;
        engine_rsp_valid  = 1'b0;
        engine_rsp_addr   = '0;
        engine_rsp_data   = '0;
        repeat (2) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;
        @(posedge ap_clk);
        seq_errors += count_mismatch("done_out", 32'(done_out), 32'd1);
        seq_errors += count_mismatch("mem_req_valid", 32'(mem_req_valid), 32'd0);
        seq_errors += count_mismatch("engine_req_valid", 32'(engine_req_valid), 32'd0);
        seq_errors += count_mismatch("engine_rsp_prog_full", 32'(engine_rsp_prog_full), 32'd0);
        seq_errors += count_mismatch("mem_rsp_prog_full", 32'(mem_rsp_prog_full), 32'd0);
        // Longer jobs than the FIFO depth force back-pressure
        run_job(engine_pkg::CMD_WRITE, 32'h0001_0000, 40);
        run_job(engine_pkg::CMD_READ, 32'h0002_0400, 24);
        run_job(engine_pkg::CMD_WRITE, 32'h8000_0ff0, 6);
        repeat (20) @(posedge ap_clk);
        finish_run();
    end

    // --------------------------------------------------
    // Memory model and random output drain
    // --------------------------------------------------
    always @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            mem_req_rd_en    <= 1'b0;
            engine_req_rd_en <= 1'b0;
        end else begin
            rd_rng = xorshift32(rd_rng);
            // Drain slower than the push rate so the FIFOs fill up
            mem_req_rd_en    <= (rd_rng[3:0] == 4'd0);
            engine_req_rd_en <= (rd_rng[7:4] == 4'd0);
            if (mem_req_valid && mem_req_cmd == engine_pkg::CMD_READ) begin
                rd_q.push_back({engine_pkg::MODULE_GENERATOR, mem_req_addr,
                                memory_word(mem_req_addr)});
                answered_cnt++;
            end
        end
    end

    // Memory response port, config packets first
    always @(posedge ap_clk) begin
        logic [64:0] ent;
        if (areset_csr_engine) begin
            mem_rsp_valid <= 1'b0;
        end else if (!mem_rsp_prog_full && (cfg_q.size() != 0 || rd_q.size() != 0)) begin
            if (cfg_q.size() != 0) begin
                ent = cfg_q.pop_front();
            end else begin
                ent = rd_q.pop_front();
            end
            mem_rsp_valid <= 1'b1;
            mem_rsp_id    <= ent[64];
            mem_rsp_addr  <= ent[63:32];
            mem_rsp_data  <= ent[31:0];
        end else begin
            mem_rsp_valid <= 1'b0;
        end
    end

    // In-order comparison of both output streams
    always @(posedge ap_clk) begin
        logic [64:0] exp_req;
        logic [63:0] exp_rsp;
        if (!areset_csr_engine && mem_req_valid) begin
            mem_seen++;
            assert (exp_mem_q.size() != 0) else begin
                $display("memory request appeared with none outstanding");
                mon_errors++;
            end
            if (exp_mem_q.size() != 0) begin
                exp_req = exp_mem_q.pop_front();
                mon_errors += count_mismatch("mem_req_cmd", 32'(mem_req_cmd), 32'(exp_req[64]));
                mon_errors += count_mismatch("mem_req_addr", mem_req_addr, exp_req[63:32]);
                if (exp_req[64] == engine_pkg::CMD_WRITE) begin
                    mon_errors += count_mismatch("mem_req_data", mem_req_data, exp_req[31:0]);
                end
            end
        end
        if (!areset_csr_engine && engine_req_valid) begin
            eng_seen++;
            assert (exp_eng_q.size() != 0) else begin
                $display("engine request appeared with none outstanding");
                mon_errors++;
            end
            if (exp_eng_q.size() != 0) begin
                exp_rsp = exp_eng_q.pop_front();
                mon_errors += count_mismatch("engine_req_addr", engine_req_addr, exp_rsp[63:32]);
                mon_errors += count_mismatch("engine_req_data", engine_req_data, exp_rsp[31:0]);
            end
        end
    end

endmodule : tb_engine_read_write

/* src.f */
+incdir+.
engine_pkg.sv
pkt_stream_if.sv
packet_fifo.sv
response_router.sv
rw_config_regs.sv
rw_generator.sv
engine_read_write.sv
tb_engine_read_write.sv

/* Makefile */
# Verilator build and run of the engine testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module tb_engine_read_write \
		-o Vtb_engine_read_write

run: compile
	./obj_dir/Vtb_engine_read_write > sim.log 2>&1 || true
	cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
